//--- hw/frv_fetch_pkg.sv
//--------------------------------------------------------------------------
// Fetch front end shared definitions
// Word width, reset PC, request limit, buffer size and the port bundles
//--------------------------------------------------------------------------

`default_nettype none

package frv_fetch_pkg;

    // Core data and address width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;    // Address or data word

    // First fetch address out of reset
    localparam word_t pc_reset_value = 32'h8000_0000;

    // Requests in flight before a new one is held back
    localparam int unsigned max_reqs_outstanding = 0;

    localparam int buf_halfwords = 4;   // Buffer capacity

    //--------------------------------------------------------------------------
    // Port bundles
    //--------------------------------------------------------------------------

    // Control flow change from the core
    typedef struct packed {
        logic  req;         // Change requested
        word_t target;      // New PC, may be halfword aligned
    } cf_t;

    // Read request to instruction memory
    typedef struct packed {
        logic  req;         // Held until granted
        word_t addr;        // Always word aligned
    } imem_req_t;

    // Read response, held by memory until acked
    typedef struct packed {
        logic  recv;        // Response present
        logic  error;       // Bus error on this word
        word_t rdata;
    } imem_rsp_t;

    // One instruction towards decode
    typedef struct packed {
        logic  valid;
        logic  error;       // Any halfword used had an error
        logic  is_16;       // Compressed encoding
        word_t data;        // Zero extended when compressed
    } instr_t;

endpackage

`default_nettype wire

//--- hw/frv_fetch_ctrl.sv
//--------------------------------------------------------------------------
// Fetch controller
// Keeps the fetch address, issues word reads to instruction memory,
// counts reads in flight and drops responses made stale by a jump
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_fetch_ctrl (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire frv_fetch_pkg::cf_t        cf,          // Control flow change
    output logic                           cf_ack,
    output frv_fetch_pkg::imem_req_t       imem_req,
    input  wire                            imem_gnt,
    input  wire frv_fetch_pkg::imem_rsp_t  imem_rsp,
    input  wire                            buf_ready,   // Buffer can take data
    input  wire                            needs_fill,  // Half a 32-bit instr waiting
    output logic                           store_word,
    output logic                           store_upper
);

    logic                 req_q;
    logic                 req_d;
    frv_fetch_pkg::word_t addr_q;
    logic                 grant;          // Request taken this cycle
    logic                 rsp_recv;       // Response transferred this cycle
    logic                 cf_change;      // Jump accepted
    logic [2:0]           reqs_q;         // Granted and not yet answered
    logic [2:0]           reqs_d;
    logic [2:0]           ignore_q;       // Stale responses still to come
    logic                 drop_rsp;
    logic                 misaligned_q;   // Next word only has upper half wanted
    logic                 misaligned_d;

    //--------------------------------------------------------------------------
    // Handshakes
    //--------------------------------------------------------------------------

    assign grant     = req_q && imem_gnt;
    assign rsp_recv  = imem_rsp.recv && buf_ready;     // Ack is the buffer ready
    assign cf_ack    = !req_q || imem_gnt;             // Nothing pending or just granted
    assign cf_change = cf.req && cf_ack;

    assign imem_req.req  = req_q;
    assign imem_req.addr = addr_q;

    //--------------------------------------------------------------------------
    // Request generation
    //--------------------------------------------------------------------------

    // Count after this cycle with stale ones included
    assign reqs_d = reqs_q + {2'b00, grant} - {2'b00, rsp_recv};

    // Hold a stalled request, refill a split instr, else only with room
    assign req_d = ((buf_ready || cf_change) &&
                    ({29'b0, reqs_d} <= frv_fetch_pkg::max_reqs_outstanding)) ||
                   needs_fill ||
                   (req_q && !imem_gnt);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req_d;
        end
    end

    // Jump target wins over sequential advance
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            addr_q <= frv_fetch_pkg::pc_reset_value;
        end else if (cf_change) begin
            addr_q <= {cf.target[31:2], 2'b00};    // Word aligned read
        end else if (grant) begin
            addr_q <= addr_q + 32'd4;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reqs_q <= 3'd0;
        end else begin
            reqs_q <= reqs_d;
        end
    end

    // Everything in flight at a jump belongs to the old stream
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ignore_q <= 3'd0;
        end else if (cf_change) begin
            ignore_q <= reqs_d;
        end else if (drop_rsp) begin
            ignore_q <= ignore_q - {2'b00, rsp_recv};
        end
    end

    assign drop_rsp = |ignore_q;

    //--------------------------------------------------------------------------
    // Misalignment and store select
    //--------------------------------------------------------------------------

    // Set by a jump onto bit 1 and gone after one upper half store
    assign misaligned_d = cf_change ? cf.target[1] : (misaligned_q && !store_upper);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            misaligned_q <= 1'b0;
        end else begin
            misaligned_q <= misaligned_d;
        end
    end

    assign store_word  = rsp_recv && !misaligned_q && !drop_rsp;
    assign store_upper = rsp_recv &&  misaligned_q && !drop_rsp;

    //--------------------------------------------------------------------------
    // Checks
    //--------------------------------------------------------------------------

    // Stale responses are only ever ones still in flight
    ignore_bound_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        ignore_q <= reqs_q);

    // In flight count bounded by the memory side
    reqs_bound_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        reqs_q <= 3'd4);

endmodule

`default_nettype wire

//--- hw/frv_fetch_buffer.sv
//--------------------------------------------------------------------------
// Fetch buffer
// Four halfword shift register, takes whole words or upper halves and
// presents the oldest complete 16 or 32-bit instruction to decode
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_fetch_buffer (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire                            flush,        // Drop everything held
    input  wire                            store_word,   // Take both halves
    input  wire                            store_upper,  // Take bits 31:16 only
    input  wire frv_fetch_pkg::imem_rsp_t  rsp,
    input  wire                            busy,         // Decode stalled
    output logic                           ready,
    output logic                           needs_fill,
    output frv_fetch_pkg::instr_t          instr
);

    localparam int nhw     = frv_fetch_pkg::buf_halfwords;
    localparam int depth_w = $clog2(nhw) + 1;     // Holds 0..nhw

    logic [15:0]        hw_q [nhw];     // Slot 0 is the oldest
    logic [15:0]        hw_d [nhw];
    logic [nhw-1:0]     err_q;          // Error per halfword
    logic [nhw-1:0]     err_d;
    logic [depth_w-1:0] depth_q;
    logic [depth_w-1:0] depth_d;
    logic [depth_w-1:0] eat;            // Halfwords removed this cycle
    logic [depth_w-1:0] base;           // First free slot after removal
    logic               head_32;        // Head starts a 32-bit encoding
    logic               has_16;
    logic               has_32;
    logic               consume;

    //--------------------------------------------------------------------------
    // Output side
    //--------------------------------------------------------------------------

    assign head_32 = hw_q[0][1:0] == 2'b11;
    assign has_16  = (depth_q != '0) && !head_32;
    assign has_32  = (depth_q >= depth_w'(2)) && head_32;

    assign instr.valid = has_16 || has_32;
    assign instr.is_16 = !head_32;
    assign instr.error = err_q[0] | (head_32 & err_q[1]);      // OR over halves used
    assign instr.data  = head_32 ? {hw_q[1], hw_q[0]} : {16'h0000, hw_q[0]};

    assign consume = instr.valid && !busy;
    assign eat     = consume ? (head_32 ? depth_w'(2) : depth_w'(1)) : '0;

    // Lone first half of a 32-bit instr
    assign needs_fill = (depth_q == depth_w'(1)) && head_32;

    // Room for a full word
    assign ready = depth_q <= depth_w'(nhw / 2);

    //--------------------------------------------------------------------------
    // Next state
    //--------------------------------------------------------------------------

    assign base = depth_q - eat;

    always_comb begin
        int src;
        for (int i = 0; i < nhw; i++) begin
            // Shift out what decode took
            src = i + int'(eat);
            if (src < nhw) begin
                hw_d[i]  = hw_q[src];
                err_d[i] = err_q[src];
            end else begin
                hw_d[i]  = hw_q[i];
                err_d[i] = err_q[i];
            end
            // Append new data behind what is left
            if (store_word && i == int'(base)) begin
                hw_d[i]  = rsp.rdata[15:0];
                err_d[i] = rsp.error;
            end else if (store_word && i == int'(base) + 1) begin
                hw_d[i]  = rsp.rdata[31:16];
                err_d[i] = rsp.error;
            end else if (store_upper && i == int'(base)) begin
                hw_d[i]  = rsp.rdata[31:16];                // Jump onto upper half
                err_d[i] = rsp.error;
            end
        end
    end

    always_comb begin
        if (flush) begin
            depth_d = '0;
        end else if (store_word) begin
            depth_d = base + depth_w'(2);
        end else if (store_upper) begin
            depth_d = base + depth_w'(1);
        end else begin
            depth_d = base;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth_q <= '0;
        end else begin
            depth_q <= depth_d;
        end
    end

    // Halfword payload with its error bits
    always_ff @(posedge g_clk) begin
        hw_q  <= hw_d;
        err_q <= err_d;
    end

    // Controller only stores while memory sees the ack
    store_ready_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (store_word || store_upper) |-> ready);

endmodule

`default_nettype wire

//--- hw/frv_fetch_top.sv
//--------------------------------------------------------------------------
// Instruction fetch front end
// Fetch controller and fetch buffer between memory and decode
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_fetch_top (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire frv_fetch_pkg::cf_t        cf,
    output wire                            cf_ack,
    input  wire                            flush,      // With an accepted jump
    output wire frv_fetch_pkg::imem_req_t  imem_req,
    input  wire                            imem_gnt,
    input  wire frv_fetch_pkg::imem_rsp_t  imem_rsp,
    output wire                            imem_ack,   // Buffer has room
    output wire frv_fetch_pkg::instr_t     instr,
    input  wire                            busy        // Decode back-pressure
);

    wire store_word;    // Whole response word into buffer
    wire store_upper;   // Upper half only
    wire needs_fill;    // Split 32-bit instr waiting

    frv_fetch_ctrl ctrl_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .cf          (cf),
        .cf_ack      (cf_ack),
        .imem_req    (imem_req),
        .imem_gnt    (imem_gnt),
        .imem_rsp    (imem_rsp),
        .buf_ready   (imem_ack),
        .needs_fill  (needs_fill),
        .store_word  (store_word),
        .store_upper (store_upper)
    );

    frv_fetch_buffer buffer_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .flush       (flush),
        .store_word  (store_word),
        .store_upper (store_upper),
        .rsp         (imem_rsp),
        .busy        (busy),
        .ready       (imem_ack),
        .needs_fill  (needs_fill),
        .instr       (instr)
    );

endmodule

`default_nettype wire

//--- tb/frv_fetch_clkgen.sv
//--------------------------------------------------------------------------
// Testbench clock and reset
// Free running clock, reset low for a fixed number of cycles
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_fetch_clkgen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 10
) (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #(period_ns / 2) g_clk = ~g_clk;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        g_resetn = 1'b0;
        repeat (reset_cycles) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
    end

endmodule

`default_nettype wire

//--- include/frv_fetch_mem.svh
//--------------------------------------------------------------------------
// Instruction memory contents for the fetch testbench
// Word data and bus error as pure functions of the address
//--------------------------------------------------------------------------

// Hash of the whole word address, biased towards 32-bit encodings
function automatic frv_fetch_pkg::word_t mem_word(input frv_fetch_pkg::word_t addr);
    frv_fetch_pkg::word_t h;
    h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b9;
    h = h ^ (h >> 13);
    if (h[21]) begin
        h[1:0] = 2'b11;         // Lower half opens a 32-bit instr
    end
    if (h[22]) begin
        h[17:16] = 2'b11;       // Upper half too
    end
    return h;
endfunction

// Four words at 0x8000_0100 answer with a bus error
function automatic logic mem_err(input frv_fetch_pkg::word_t addr);
    return (addr & 32'hffff_fff0) == 32'h8000_0100;
endfunction

//--- tb/frv_fetch_imem_model.sv
//--------------------------------------------------------------------------
// Instruction memory model
// Random grant and response delay, in order responses, at most two
// reads in flight, data and error taken from the address
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_fetch_imem_model #(
    parameter int unsigned seed_init = 32'h0000_0001
) (
    input  wire                            g_clk,
    input  wire                            g_resetn,
    input  wire frv_fetch_pkg::imem_req_t  imem_req,
    output logic                           imem_gnt,
    output frv_fetch_pkg::imem_rsp_t       imem_rsp,
    input  wire                            imem_ack
);

`include "frv_fetch_mem.svh"

    localparam int max_in_flight = 2;

    integer               seed;
    frv_fetch_pkg::word_t pend [$];     // Granted, head is being answered
    logic                 took_req;     // Transfers seen on the last edge
    logic                 took_rsp;
    int                   gnt_wait;     // Cycles before the next grant
    int                   rsp_wait;     // Cycles before the head answers

    initial begin
        seed     = seed_init;
        imem_gnt = 1'b0;
        imem_rsp = '0;
        took_req = 1'b0;
        took_rsp = 1'b0;
        gnt_wait = 0;
        rsp_wait = 1;
    end

    // Record what the DUT took on this edge
    always @(posedge g_clk) begin
        took_req = g_resetn && imem_req.req && imem_gnt;
        took_rsp = g_resetn && imem_rsp.recv && imem_ack;
        if (!g_resetn) begin
            pend.delete();
        end
        if (took_rsp) begin
            pend.delete(0);
        end
        if (took_req) begin
            pend.push_back(imem_req.addr);
        end
    end

    always @(negedge g_clk) begin
        if (!g_resetn) begin
            imem_gnt = 1'b0;
            imem_rsp = '0;
            gnt_wait = 0;
            rsp_wait = 1;
        end else begin
            // Grant side, 0 to 2 cycles
            if (took_req) begin
                gnt_wait = $unsigned($random(seed)) % 3;
            end
            if (imem_req.req && pend.size() < max_in_flight && gnt_wait == 0) begin
                imem_gnt = 1'b1;
            end else begin
                imem_gnt = 1'b0;
                if (imem_req.req && gnt_wait > 0) begin
                    gnt_wait--;
                end
            end
            // Response side, 1 to 3 cycles, held until acked
            if (took_rsp) begin
                imem_rsp = '0;
                rsp_wait = 1 + $unsigned($random(seed)) % 3;
            end
            if (!imem_rsp.recv && pend.size() != 0) begin
                rsp_wait--;
                if (rsp_wait <= 0) begin
                    imem_rsp.recv  = 1'b1;
                    imem_rsp.error = mem_err(pend[0]);
                    imem_rsp.rdata = mem_word(pend[0]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/frv_fetch_tb.sv
//--------------------------------------------------------------------------
// Fetch front end testbench
// Reset fetch, compressed mix, redirects, back-pressure and bus errors
// against a software walk of the same memory image
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frv_fetch_tb;

`include "frv_fetch_mem.svh"

    localparam int          clk_period = 4;
    localparam int unsigned seed_value = 32'hccc6_e1b6;
    localparam int          n_reset    = 40;
    localparam int          n_mix      = 60;
    localparam int          n_jump     = 20;    // Per redirect
    localparam int          n_bp       = 80;
    localparam int          n_err      = 30;
    localparam int          watchdog_ns =
        200 * clk_period * (n_reset + n_mix + 2 * n_jump + n_bp + n_err);

    wire                            g_clk;
    wire                            g_resetn;
    frv_fetch_pkg::cf_t             cf;
    wire                            cf_ack;
    wire                            flush;
    wire frv_fetch_pkg::imem_req_t  imem_req;
    wire                            imem_gnt;
    wire frv_fetch_pkg::imem_rsp_t  imem_rsp;
    wire                            imem_ack;
    wire frv_fetch_pkg::instr_t     instr;
    logic                           busy;

    integer                seed;
    logic                  bp_mode;                 // Random busy on
    frv_fetch_pkg::word_t  exp_pc   = frv_fetch_pkg::pc_reset_value;
    frv_fetch_pkg::word_t  exp_addr = frv_fetch_pkg::pc_reset_value;
    frv_fetch_pkg::instr_t held;                    // Reference instr stalled by busy
    logic                  held_v   = 1'b0;
    int                    n_checks = 0;
    int                    n_errors = 0;
    int                    n_consumed = 0;
    int                    n_split  = 0;            // 32-bit across two words
    int                    n_flagged = 0;
    int                    n_out    = 0;            // Granted reads still unanswered
    int                    n_stale  = 0;            // Answers the DUT must drop
    int                    buf_fill = 0;            // Halfwords the buffer should hold
    logic                  upper_only = 1'b0;       // Next kept answer gives its upper half

    // Core raises flush with every accepted jump
    assign flush = cf.req && cf_ack;

    frv_fetch_clkgen #(.period_ns(clk_period), .reset_cycles(10)) clkgen_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    frv_fetch_imem_model #(.seed_init(seed_value)) imem_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .imem_req (imem_req),
        .imem_gnt (imem_gnt),
        .imem_rsp (imem_rsp),
        .imem_ack (imem_ack)
    );

    frv_fetch_top dut_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .cf       (cf),
        .cf_ack   (cf_ack),
        .flush    (flush),
        .imem_req (imem_req),
        .imem_gnt (imem_gnt),
        .imem_rsp (imem_rsp),
        .imem_ack (imem_ack),
        .instr    (instr),
        .busy     (busy)
    );

    //--------------------------------------------------------------------------
    // Reference and compare
    //--------------------------------------------------------------------------

    function automatic logic [15:0] halfword_at(input frv_fetch_pkg::word_t a);
        frv_fetch_pkg::word_t w;
        w = mem_word({a[31:2], 2'b00});
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    // Instruction that starts at pc
    function automatic frv_fetch_pkg::instr_t next_instr(input frv_fetch_pkg::word_t pc);
        frv_fetch_pkg::instr_t r;
        logic [15:0]           lo;
        logic [15:0]           hi;
        lo      = halfword_at(pc);
        hi      = halfword_at(pc + 32'd2);
        r.valid = 1'b1;
        r.is_16 = lo[1:0] != 2'b11;
        r.data  = r.is_16 ? {16'h0000, lo} : {hi, lo};
        r.error = mem_err(pc) | (!r.is_16 & mem_err(pc + 32'd2));
        return r;
    endfunction

    task automatic check_instr(input string what, input frv_fetch_pkg::instr_t got,
                               input frv_fetch_pkg::instr_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error %s: valid %h error %h is_16 %h data %h, expected %h %h %h %h",
                     what, got.valid, got.error, got.is_16, got.data,
                     exp.valid, exp.error, exp.is_16, exp.data);
        end
    endtask

    task automatic check_addr(input string what, input frv_fetch_pkg::word_t got,
                              input frv_fetch_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic note_failure(input string why);
        n_errors++;
        $display("%s", why);
    endtask

    always @(posedge g_clk) begin
        frv_fetch_pkg::instr_t exp;
        if (g_resetn) begin
            // Jump taken when idle or on the pending grant
            check_bit("cf_ack", cf_ack, !imem_req.req || imem_gnt);
            // Memory waits once more than two halfwords are held
            check_bit("imem_ack", imem_ack, buf_fill <= 2);
            if (held_v) begin
                check_instr("instr held under busy", instr, held);
            end
            held_v = instr.valid && busy && !flush;
            held   = next_instr(exp_pc);
            if (imem_req.req && imem_gnt) begin         // Grant takes the next word in line
                check_addr("imem_req.addr", imem_req.addr, exp_addr);
                exp_addr = exp_addr + 32'd4;
                n_out++;
            end
            if (imem_rsp.recv && imem_ack) begin        // Answer taken by the buffer
                n_out--;
                if (n_stale > 0) begin
                    n_stale--;
                end else begin
                    buf_fill   = buf_fill + (upper_only ? 1 : 2);
                    upper_only = 1'b0;
                end
            end
            if (instr.valid && !busy) begin
                exp = next_instr(exp_pc);
                check_instr($sformatf("instr at pc %h", exp_pc), instr, exp);
                if (!exp.is_16 && exp_pc[1]) begin
                    n_split++;
                end
                if (exp.error) begin
                    n_flagged++;
                end
                buf_fill = buf_fill - (exp.is_16 ? 1 : 2);
                exp_pc   = exp_pc + (exp.is_16 ? 32'd2 : 32'd4);
                n_consumed++;
            end
            if (cf.req && cf_ack) begin                 // Both streams restart
                exp_pc     = cf.target;
                exp_addr   = {cf.target[31:2], 2'b00};
                n_stale    = n_out;                     // Old stream still in flight
                buf_fill   = 0;
                upper_only = cf.target[1];
            end
        end
    end

    //--------------------------------------------------------------------------
    // Stimulus
    //--------------------------------------------------------------------------

    task automatic run_instrs(input int n);
        int goal;
        goal = n_consumed + n;
        while (n_consumed < goal) begin
            @(negedge g_clk);
            busy = bp_mode && (($random(seed) & 1) != 0);
        end
        @(negedge g_clk);
        busy = 1'b0;
    endtask

    // Raised under a pending read so the jump lands on its grant
    task automatic redirect(input frv_fetch_pkg::word_t target);
        do @(negedge g_clk); while (!imem_req.req);
        cf.req    = 1'b1;
        cf.target = target;
        do @(posedge g_clk); while (!cf_ack);
        @(negedge g_clk);
        cf.req = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("test %-14s done, %0d consumed so far, %0d errors",
                 name, n_consumed, n_errors - err_start);
    endtask

    initial begin
        int                   err_start;
        int                   mark;
        frv_fetch_pkg::word_t target;
        seed    = seed_value;
        cf      = '0;
        busy    = 1'b0;
        bp_mode = 1'b0;
        wait (g_resetn);

        err_start = n_errors;
        run_instrs(n_reset);
        report_test("reset fetch", err_start);

        err_start = n_errors;
        mark      = n_split;
        run_instrs(n_mix);
        if (n_split == mark) begin
            note_failure("No 32-bit instruction split across two words was fetched");
        end
        report_test("compressed mix", err_start);

        err_start = n_errors;
        target    = frv_fetch_pkg::pc_reset_value + 32'h1000 + ($random(seed) & 32'hffc);
        redirect(target);
        run_instrs(n_jump);
        target    = frv_fetch_pkg::pc_reset_value + 32'h1000 + ($random(seed) & 32'hffc);
        redirect(target + 32'd2);                       // Upper half of a word
        run_instrs(n_jump);
        report_test("redirect", err_start);

        err_start = n_errors;
        bp_mode   = 1'b1;
        run_instrs(n_bp);
        bp_mode   = 1'b0;
        report_test("back-pressure", err_start);

        err_start = n_errors;
        mark      = n_flagged;
        redirect(32'h8000_00f0);                        // Runs through the error words
        run_instrs(n_err);
        if (n_flagged == mark) begin
            note_failure("No instruction from the error window was fetched");
        end
        report_test("bus error", err_start);

        $display("%0d instructions, %0d checks, %0d errors", n_consumed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout after %0d ns, instruction stream stalled", watchdog_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- frv_fetch_top.f
+incdir+include
hw/frv_fetch_pkg.sv
hw/frv_fetch_ctrl.sv
hw/frv_fetch_buffer.sv
hw/frv_fetch_top.sv
tb/frv_fetch_clkgen.sv
tb/frv_fetch_imem_model.sv
tb/frv_fetch_tb.sv
